//--- switch_ingress.f
+incdir+rtl
rtl/switch_pkg.sv
rtl/sync_fifo.sv
rtl/rx_port_buffer.sv
rtl/interface_mux.sv
rtl/switch_ingress_top.sv
testbench/tb_switch_ingress.sv

//--- testbench/switch_stim.txt
# test <name> | frame <port> <length> <err> | send | wait <cycles>
# stall | release | drain | idle (no merged descriptor may be waiting)
test reset_idle
wait 50
idle
test single_per_port
frame 0 64 0
frame 1 5 0
frame 2 100 0
frame 3 9 0
send
drain
test errored_and_runt
frame 0 30 1
frame 0 4 0
frame 0 25 0
frame 1 60 0
frame 1 12 1
send
drain
test all_ports
frame 0 300 0
frame 1 2047 0
frame 1 3 0
frame 2 128 0
frame 2 6 0
frame 3 64 0
send
drain
test backpressure
stall
frame 0 1600 0
frame 0 1600 0
frame 1 1600 0
frame 2 1600 0
frame 3 1600 0
send
wait 8000
release
drain
idle

//--- testbench/tb_switch_ingress.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module tb_switch_ingress;

    logic                    clk;
    logic                    rstn;
    switch_pkg::rx_byte_t    rx_drv [4];
    logic                    merge_byte_rd;
    logic [7:0]              merge_byte;
    logic                    merge_desc_rd;
    switch_pkg::merge_desc_t merge_desc;
    logic                    merge_desc_empty;

    switch_pkg::rx_byte_t tx_q [4][$];
    logic [7:0]           exp_byte_q [4][$];
    logic [10:0]          exp_len_q [4][$];
    string                cmd_name_q [$];
    string                cmd_text_q [$];
    int                   cmd_a_q [$];
    int                   cmd_b_q [$];
    int                   cmd_c_q [$];
    string                cur_test = "none";
    logic [15:0]          lfsr_state;
    int                   total_bytes;
    int                   total_wait;
    int                   watchdog_limit;
    logic                 stalled;
    logic                 reading;

    switch_ingress_top dut_i (
        .clk              (clk),
        .rstn             (rstn),
        .rx_in0           (rx_drv[0]),
        .rx_in1           (rx_drv[1]),
        .rx_in2           (rx_drv[2]),
        .rx_in3           (rx_drv[3]),
        .merge_byte_rd    (merge_byte_rd),
        .merge_byte       (merge_byte),
        .merge_desc_rd    (merge_desc_rd),
        .merge_desc       (merge_desc),
        .merge_desc_empty (merge_desc_empty)
    );

    always #5 clk = ~clk;

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_desc(input switch_pkg::merge_desc_t exp,
                              input switch_pkg::merge_desc_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED test %s descriptor expected %h actual %h",
                                cur_test, exp, act));
        end
    endtask

    task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED test %s byte expected %h actual %h",
                                cur_test, exp, act));
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_data_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic int port_of(input logic [3:0] map);
        int p;
        p = -1;
        for (int i = 0; i < 4; i++) begin
            if (map == 4'(1 << i)) begin
                p = i;
            end
        end
        return p;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int p = 0; p < 4; p++) begin
            n += exp_len_q[p].size() + exp_byte_q[p].size();
        end
        return n;
    endfunction

    // Good frames lose their check field and bad ones are never expected
    task automatic queue_frame(input int port, input int len, input int err);
        switch_pkg::rx_byte_t rb;
        logic                 good;
        good = (err == 0) && (len >= `SW_MIN_FRAME);
        for (int i = 0; i < len; i++) begin
            rb.valid = 1'b1;
            rb.last  = (i == len - 1);
            rb.err   = (err != 0) && (i == len / 2);
            next_data_byte(rb.data);
            tx_q[port].push_back(rb);
            if (good && i < len - `SW_CRC_BYTES) begin
                exp_byte_q[port].push_back(rb.data);
            end
        end
        if (good) begin
            exp_len_q[port].push_back(11'(len - `SW_CRC_BYTES));
        end
    endtask

    // All ports are driven side by side until every send queue is empty
    task automatic send_frames();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int p = 0; p < 4; p++) begin
                if (tx_q[p].size() > 0) begin
                    rx_drv[p] = tx_q[p].pop_front();
                    busy      = 1'b1;
                end else begin
                    rx_drv[p] = '0;
                end
            end
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    code;
        string word;
        string rest;
        int    a;
        int    b;
        int    c;
        fd = $fopen("testbench/switch_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file testbench/switch_stim.txt");
        end
        while (!$feof(fd)) begin
            a    = 0;
            b    = 0;
            c    = 0;
            rest = "";
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                break;
            end
            if (word.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
                continue;
            end else if (word == "test") begin
                code = $fscanf(fd, "%s", rest);
            end else if (word == "frame") begin
                code = $fscanf(fd, "%d %d %d", a, b, c);
                total_bytes += b;
            end else if (word == "wait") begin
                code = $fscanf(fd, "%d", a);
                total_wait += a;
            end else if (word != "send" && word != "stall" && word != "release" &&
                         word != "drain" && word != "idle") begin
                abort_run($sformatf("Unknown command %s in the stimulus file", word));
            end
            cmd_name_q.push_back(word);
            cmd_text_q.push_back(rest);
            cmd_a_q.push_back(a);
            cmd_b_q.push_back(b);
            cmd_c_q.push_back(c);
        end
        $fclose(fd);
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        stalled       = 1'b0;
        total_bytes   = 0;
        total_wait    = 0;
        lfsr_state    = 16'd30;
        for (int p = 0; p < 4; p++) begin
            rx_drv[p] = '0;
        end
        load_stimulus();
        watchdog_limit = 20 * total_bytes + total_wait + 2000;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (merge_desc_empty !== 1'b1) begin
            abort_run("merge_desc_empty is not high after reset");
        end
        for (int k = 0; k < cmd_name_q.size(); k++) begin
            if (cmd_name_q[k] == "test") begin
                cur_test = cmd_text_q[k];
            end else if (cmd_name_q[k] == "frame") begin
                queue_frame(cmd_a_q[k], cmd_b_q[k], cmd_c_q[k]);
            end else if (cmd_name_q[k] == "send") begin
                send_frames();
            end else if (cmd_name_q[k] == "wait") begin
                repeat (cmd_a_q[k]) @(negedge clk);
            end else if (cmd_name_q[k] == "stall") begin
                stalled = 1'b1;
            end else if (cmd_name_q[k] == "release") begin
                stalled = 1'b0;
            end else if (cmd_name_q[k] == "drain") begin
                while (pending_count() != 0 || reading) begin
                    @(negedge clk);
                end
            end else if (merge_desc_empty !== 1'b1) begin
                abort_run($sformatf("Test %s found a merged descriptor it did not expect",
                                    cur_test));
            end
        end
        repeat (20) @(negedge clk);
        if (pending_count() != 0 || merge_desc_empty !== 1'b1) begin
            abort_run("Frames were left undelivered or extra output appeared at the end");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // -------------------------------------------------------------------------
    // Output reader
    // -------------------------------------------------------------------------
    initial begin
        switch_pkg::merge_desc_t got;
        switch_pkg::merge_desc_t exp;
        int                      p;
        merge_byte_rd = 1'b0;
        merge_desc_rd = 1'b0;
        reading       = 1'b0;
        wait (rstn === 1'b1);
        forever begin
            @(negedge clk);
            if (!stalled && merge_desc_empty === 1'b0) begin
                reading = 1'b1;
                got     = merge_desc;
                p       = port_of(got.port_map);
                if (p < 0) begin
                    abort_run($sformatf("Test %s got a port map %b that is not one-hot",
                                        cur_test, got.port_map));
                end
                if (exp_len_q[p].size() == 0) begin
                    abort_run($sformatf("Test %s got a frame from port %0d it never sent",
                                        cur_test, p));
                end
                exp          = '0;
                exp.port_map = 4'(1 << p);
                exp.len      = exp_len_q[p].pop_front();
                check_desc(exp, got);
                merge_desc_rd = 1'b1;
                @(negedge clk);
                merge_desc_rd = 1'b0;
                for (int i = 0; i < int'(got.len); i++) begin
                    check_byte(exp_byte_q[p].pop_front(), merge_byte);
                    merge_byte_rd = 1'b1;
                    @(negedge clk);
                end
                merge_byte_rd = 1'b0;
                reading       = 1'b0;
            end
        end
    end

    initial begin
        wait (watchdog_limit > 0);
        repeat (watchdog_limit) @(posedge clk);
        abort_run($sformatf("Timeout in test %s after %0d cycles", cur_test, watchdog_limit));
    end

endmodule

//--- rtl/switch_ingress_top.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module switch_ingress_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  switch_pkg::rx_byte_t    rx_in0,
    input  switch_pkg::rx_byte_t    rx_in1,
    input  switch_pkg::rx_byte_t    rx_in2,
    input  switch_pkg::rx_byte_t    rx_in3,
    input  logic                    merge_byte_rd,
    output logic [7:0]              merge_byte,
    input  logic                    merge_desc_rd,
    output switch_pkg::merge_desc_t merge_desc,
    output logic                    merge_desc_empty
);

    switch_pkg::rx_byte_t     rx_in [`SW_NUM_PORTS];
    logic [7:0]               port_byte [`SW_NUM_PORTS];
    switch_pkg::rx_desc_t     port_desc [`SW_NUM_PORTS];
    logic [`SW_NUM_PORTS-1:0] port_byte_rd;
    logic [`SW_NUM_PORTS-1:0] port_desc_rd;
    logic [`SW_NUM_PORTS-1:0] port_desc_empty;

    assign rx_in[0] = rx_in0;
    assign rx_in[1] = rx_in1;
    assign rx_in[2] = rx_in2;
    assign rx_in[3] = rx_in3;

    // ---------------------------------------------------------------------------
    // Per-port receive buffers
    // ---------------------------------------------------------------------------
    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_port
        rx_port_buffer port_buf_i (
            .clk        (clk),
            .rstn       (rstn),
            .rx_in      (rx_in[p]),
            .byte_rd    (port_byte_rd[p]),
            .data_byte  (port_byte[p]),
            .desc_rd    (port_desc_rd[p]),
            .desc       (port_desc[p]),
            .desc_empty (port_desc_empty[p])
        );
    end

    // ---------------------------------------------------------------------------
    // Merge stage
    // ---------------------------------------------------------------------------
    interface_mux mux_i (
        .clk              (clk),
        .rstn             (rstn),
        .byte_in          (port_byte),
        .byte_rd          (port_byte_rd),
        .desc_in          (port_desc),
        .desc_rd          (port_desc_rd),
        .desc_empty       (port_desc_empty),
        .merge_byte_rd    (merge_byte_rd),
        .merge_byte       (merge_byte),
        .merge_desc_rd    (merge_desc_rd),
        .merge_desc       (merge_desc),
        .merge_desc_empty (merge_desc_empty)
    );

endmodule

//--- rtl/interface_mux.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module interface_mux (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [7:0]                  byte_in [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0]    byte_rd,
    input  switch_pkg::rx_desc_t        desc_in [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0]    desc_rd,
    input  logic [`SW_NUM_PORTS-1:0]    desc_empty,
    input  logic                        merge_byte_rd,
    output logic [7:0]                  merge_byte,
    input  logic                        merge_desc_rd,
    output switch_pkg::merge_desc_t     merge_desc,
    output logic                        merge_desc_empty
);

    typedef enum logic [1:0] {
        st_idle,
        st_desc,
        st_data,
        st_wdesc
    } state_t;

    state_t                  state;
    logic [1:0]              rr_ptr;
    logic [1:0]              sel;
    logic [1:0]              grant_sel;
    logic                    grant_any;
    logic [3:0]              port_map;
    logic [12:0]             cnt;
    logic                    bad;
    logic [12:0]             frame_len;
    logic                    bp;
    logic [$clog2(`SW_MERGE_DATA_DEPTH+1)-1:0] merge_count;
    logic                    merge_desc_full;
    logic                    data_wr;
    logic                    desc_wr;
    switch_pkg::merge_desc_t desc_din;

    // ---------------------------------------------------------------------------
    // Round-robin pick
    // ---------------------------------------------------------------------------

    // Search starts at the priority pointer and wraps around
    always_comb begin
        logic [1:0] idx;
        grant_any = 1'b0;
        grant_sel = rr_ptr;
        idx       = rr_ptr;
        for (int i = 0; i < `SW_NUM_PORTS; i++) begin
            idx = rr_ptr + 2'(i);
            if (!grant_any && !desc_empty[idx]) begin
                grant_any = 1'b1;
                grant_sel = idx;
            end
        end
    end

    // Back-pressure is checked only between frames and a started frame always
    // runs to the end
    assign bp = (merge_count > `SW_BP_LEVEL) || merge_desc_full;

    // ---------------------------------------------------------------------------
    // Frame mover FSM
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= st_idle;
            rr_ptr <= '0;
            sel    <= '0;
            cnt    <= '0;
            bad    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (grant_any && !bp) begin
                        sel    <= grant_sel;
                        rr_ptr <= rr_ptr + 1'b1;
                        state  <= st_desc;
                    end
                end
                st_desc: begin
                    cnt   <= desc_in[sel].len;
                    bad   <= desc_in[sel].runt | desc_in[sel].line_err;
                    state <= st_data;
                end
                st_data: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == 13'd1) begin
                        state <= st_wdesc;
                    end
                end
                st_wdesc: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_desc) begin
            frame_len <= desc_in[sel].len;
        end
    end

    // ---------------------------------------------------------------------------
    // Strobes and shared FIFO writes
    // ---------------------------------------------------------------------------
    assign port_map = 4'b0001 << sel;

    assign desc_rd = (state == st_desc) ? port_map : '0;
    assign byte_rd = (state == st_data) ? port_map : '0;

    // cnt holds the bytes still to come, this one included, so the last
    // four pops are the check field
    assign data_wr = (state == st_data) && !bad && (cnt > 13'(`SW_CRC_BYTES));
    assign desc_wr = (state == st_wdesc) && !bad;

    always_comb begin
        desc_din          = '0;
        desc_din.port_map = port_map;
        desc_din.len      = frame_len[10:0] - 11'(`SW_CRC_BYTES);
    end

    sync_fifo #(
        .width (8),
        .depth (`SW_MERGE_DATA_DEPTH)
    ) data_fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (data_wr),
        .din   (byte_in[sel]),
        .rd    (merge_byte_rd),
        .dout  (merge_byte),
        .count (merge_count),
        .full  (),
        .empty ()
    );

    sync_fifo #(
        .width ($bits(switch_pkg::merge_desc_t)),
        .depth (`SW_MERGE_DESC_DEPTH)
    ) desc_fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (desc_wr),
        .din   (desc_din),
        .rd    (merge_desc_rd),
        .dout  (merge_desc),
        .count (),
        .full  (merge_desc_full),
        .empty (merge_desc_empty)
    );

    // A granted frame must fit in the shared byte FIFO as it stands
    a_room_for_frame: assert property (@(posedge clk) disable iff (!rstn)
        (state == st_desc) |->
            (int'(merge_count) + int'(desc_in[sel].len) - `SW_CRC_BYTES
             <= `SW_MERGE_DATA_DEPTH))
        else $error("Frame granted without room in the shared byte FIFO");

endmodule

//--- rtl/rx_port_buffer.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module rx_port_buffer (
    input  logic                 clk,
    input  logic                 rstn,
    input  switch_pkg::rx_byte_t rx_in,
    input  logic                 byte_rd,
    output logic [7:0]           data_byte,
    input  logic                 desc_rd,
    output switch_pkg::rx_desc_t desc,
    output logic                 desc_empty
);

    logic [12:0]          len_cnt;
    logic                 err_acc;
    logic [12:0]          frame_len;
    logic                 frame_err;
    logic                 desc_wr;
    switch_pkg::rx_desc_t desc_din;
    logic                 data_full;
    logic                 desc_full;

    // ---------------------------------------------------------------------------
    // Frame length and error tracking
    // ---------------------------------------------------------------------------

    // Both values include the byte on the input in this cycle
    assign frame_len = len_cnt + 13'd1;
    assign frame_err = err_acc | rx_in.err;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            len_cnt <= '0;
            err_acc <= 1'b0;
        end else if (rx_in.valid) begin
            if (rx_in.last) begin
                len_cnt <= '0;
                err_acc <= 1'b0;
            end else begin
                len_cnt <= frame_len;
                err_acc <= frame_err;
            end
        end
    end

    // The descriptor is written on the same edge as the last byte, so
    // the merge stage never sees a descriptor ahead of its data
    assign desc_wr = rx_in.valid & rx_in.last;

    always_comb begin
        desc_din          = '0;
        desc_din.runt     = (frame_len < 13'(`SW_MIN_FRAME));
        desc_din.line_err = frame_err;
        desc_din.len      = frame_len;
    end

    // ---------------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------------
    sync_fifo #(
        .width (8),
        .depth (`SW_RX_DATA_DEPTH)
    ) data_fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (rx_in.valid),
        .din   (rx_in.data),
        .rd    (byte_rd),
        .dout  (data_byte),
        .count (),
        .full  (data_full),
        .empty ()
    );

    sync_fifo #(
        .width ($bits(switch_pkg::rx_desc_t)),
        .depth (`SW_RX_DESC_DEPTH)
    ) desc_fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (desc_wr),
        .din   (desc_din),
        .rd    (desc_rd),
        .dout  (desc),
        .count (),
        .full  (desc_full),
        .empty (desc_empty)
    );

    // The sender has no flow control and must never overrun this buffer
    a_no_port_overrun: assert property (@(posedge clk) disable iff (!rstn)
        rx_in.valid |-> !data_full && !(rx_in.last && desc_full))
        else $error("Receive port overrun");

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 16
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       wr,
    input  logic [width-1:0]           din,
    input  logic                       rd,
    output logic [width-1:0]           dout,
    output logic [$clog2(depth+1)-1:0] count,
    output logic                       full,
    output logic                       empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);
    localparam logic [cnt_w-1:0] full_level = cnt_w'(depth);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head entry is always on dout
    assign dout  = mem[rd_ptr];
    assign full  = (count == full_level);
    assign empty = (count == '0);

    // The users of this FIFO are responsible for respecting the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        full |-> !wr)
        else $error("sync_fifo written while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        empty |-> !rd)
        else $error("sync_fifo read while empty");

endmodule

//--- rtl/switch_pkg.sv
package switch_pkg;

    // -----------------------------------------------------------------------
    // Receive side
    // -----------------------------------------------------------------------

    // One byte of an incoming frame
    typedef struct packed {
        logic       valid;
        logic       last;
        logic       err;
        logic [7:0] data;
    } rx_byte_t;

    // Written by a port buffer once per frame
    // The length includes the trailing check field
    typedef struct packed {
        logic        runt;
        logic        line_err;
        logic        rsvd;
        logic [12:0] len;
    } rx_desc_t;

    // -----------------------------------------------------------------------
    // Merged side
    // -----------------------------------------------------------------------

    // Only good frames get one of these
    // The port map is one-hot and the length counts payload bytes only
    typedef struct packed {
        logic        rsvd;
        logic [3:0]  port_map;
        logic [10:0] len;
    } merge_desc_t;

endpackage

//--- rtl/switch_defines.svh
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

// ---------------------------------------------------------------------------
// Port count and frame limits
// ---------------------------------------------------------------------------
`define SW_NUM_PORTS        4
// Largest frame in bytes, check field included
`define SW_MAX_FRAME        2047
`define SW_CRC_BYTES        4
`define SW_MIN_FRAME        5

// ---------------------------------------------------------------------------
// FIFO depths
// ---------------------------------------------------------------------------
`define SW_RX_DATA_DEPTH    4096
`define SW_RX_DESC_DEPTH    16
`define SW_MERGE_DATA_DEPTH 8192
`define SW_MERGE_DESC_DEPTH 32

// No new frame starts once the shared byte FIFO holds more than this
`define SW_BP_LEVEL         (`SW_MERGE_DATA_DEPTH - `SW_MAX_FRAME)

`endif
